// ==== Makefile ====
# Verilator build and run for the L2 scratchpad subsystem.

SRCS := $(shell cat l2_subsystem.f)

run: obj_dir/Vl2_subsystem_tb
	./obj_dir/Vl2_subsystem_tb > sim.log 2>&1; cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

obj_dir/Vl2_subsystem_tb: l2_subsystem.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f l2_subsystem.f --top-module l2_subsystem_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== design/l2_bank.sv ====
`timescale 1ns/1ps

module l2_bank (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input l2_pkg::l2_req_t req,
    output logic credit,
    output logic rsp_valid,
    output l2_pkg::l2_resp_t rsp,
    input logic rsp_pop
);
    import l2_pkg::*;

    l2_req_t req_head;
    logic req_not_empty;
    logic [cnt_bits-1:0] req_count;
    logic [cnt_bits-1:0] rsp_count;
    logic [cnt_bits:0] reserved;
    logic pop_req;
    logic rd_issue;
    logic rd_pending;
    logic [tag_bits-1:0] rd_tag;
    logic [data_bits-1:0] rd_data;
    logic [strb_bits-1:0] wr_en;
    l2_resp_t rsp_push_data;

    l2_fifo #(
        .payload_t(l2_req_t),
        .depth(bank_depth)
    ) req_fifo_inst (
        .clk(clk),
        .reset(reset),
        .push(req_valid),
        .push_data(req),
        .pop(pop_req),
        .head(req_head),
        .not_empty(req_not_empty),
        .count(req_count)
    );

    // Space already promised to reads, counting the one still in the RAM.
    assign reserved = (cnt_bits + 1)'(rsp_count) + (cnt_bits + 1)'(rd_pending);

    // writes need no response slot and are never held back here.
    assign pop_req = req_not_empty &&
                     (req_head.write || reserved < (cnt_bits + 1)'(bank_depth));
    assign rd_issue = pop_req && !req_head.write;
    assign wr_en = (pop_req && req_head.write) ? req_head.byte_en : '0;
    assign credit = pop_req;   // the freed slot goes straight back to the dispatcher.

    l2ram l2ram_inst (
        .clk(clk),
        .rd_en(rd_issue),
        .rd_addr(row_of(req_head.addr)),
        .rd_data(rd_data),
        .wr_en(wr_en),
        .wr_addr(row_of(req_head.addr)),
        .wr_data(req_head.data)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            rd_tag <= req_head.tag;   // lines up with rd_data one cycle later.
        end
    end

    assign rsp_push_data = '{tag: rd_tag, data: rd_data};

    l2_fifo #(
        .payload_t(l2_resp_t),
        .depth(bank_depth)
    ) rsp_fifo_inst (
        .clk(clk),
        .reset(reset),
        .push(rd_pending),
        .push_data(rsp_push_data),
        .pop(rsp_pop),
        .head(rsp),
        .not_empty(rsp_valid),
        .count(rsp_count)
    );

    // A full request queue here means the dispatcher sent without a credit.
    a_credit_rule: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> req_count < cnt_bits'(bank_depth))
        else $error("l2_bank: request arrived with no free slot");

endmodule

// ==== design/l2_fifo.sv ====
`timescale 1ns/1ps

module l2_fifo #(
    parameter type payload_t = logic,
    parameter int depth = 4
) (
    input logic clk,
    input logic reset,
    input logic push,
    input payload_t push_data,
    input logic pop,
    output payload_t head,
    output logic not_empty,
    output logic [$clog2(depth + 1)-1:0] count
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;   // both or neither leave occupancy unchanged.
            endcase
        end
    end

    assign head = mem[rd_ptr];
    assign not_empty = (count != '0);

    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        push |-> count != cnt_w'(depth))
        else $error("l2_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> count != '0)
        else $error("l2_fifo: pop while empty");

endmodule

// ==== design/l2_pkg.sv ====
package l2_pkg;

    localparam int num_banks = 4;
    localparam int bank_bits = 2;
    localparam int row_bits = 11;
    localparam int addr_bits = bank_bits + row_bits;   // word address, bank index in the low bits.
    localparam int data_bits = 128;
    localparam int strb_bits = data_bits / 8;
    localparam int tag_bits = 6;

    localparam int in_depth = 4;       // also the requester's starting credit count.
    localparam int bank_depth = 4;     // per-bank queue depth and dispatcher credit per bank.
    localparam int resp_credits = 4;

    // counter widths that can hold the full credit values.
    localparam int cnt_bits = $clog2(bank_depth + 1);
    localparam int resp_cnt_bits = $clog2(resp_credits + 1);

    typedef struct packed {
        logic write;                     // set for a write, clear for a read.
        logic [addr_bits-1:0] addr;
        logic [strb_bits-1:0] byte_en;   // only used by writes.
        logic [data_bits-1:0] data;
        logic [tag_bits-1:0] tag;        // echoed back on the read response.
    } l2_req_t;

    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [data_bits-1:0] data;
    } l2_resp_t;

    // Consecutive words go to consecutive banks.
    function automatic logic [bank_bits-1:0] bank_of(input logic [addr_bits-1:0] addr);
        return addr[bank_bits-1:0];
    endfunction

    function automatic logic [row_bits-1:0] row_of(input logic [addr_bits-1:0] addr);
        return addr[addr_bits-1:bank_bits];
    endfunction

endpackage

// ==== design/l2_req_dispatch.sv ====
`timescale 1ns/1ps

module l2_req_dispatch (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input l2_pkg::l2_req_t req,
    output logic req_credit,
    output logic [l2_pkg::num_banks-1:0] bank_req_valid,
    output l2_pkg::l2_req_t bank_req,
    input logic [l2_pkg::num_banks-1:0] bank_credit
);
    import l2_pkg::*;

    l2_req_t in_head;
    logic in_not_empty;
    logic [bank_bits-1:0] head_bank;
    logic send;
    logic [cnt_bits-1:0] bank_cnt [num_banks];

    // the requester's credits guarantee this queue never overflows.
    l2_fifo #(
        .payload_t(l2_req_t),
        .depth(in_depth)
    ) in_fifo_inst (
        .clk(clk),
        .reset(reset),
        .push(req_valid),
        .push_data(req),
        .pop(send),
        .head(in_head),
        .not_empty(in_not_empty),
        .count()
    );

    assign head_bank = bank_of(in_head.addr);

    // A head waiting on a busy bank also blocks everything behind it.
    assign send = in_not_empty && (bank_cnt[head_bank] != '0);
    assign req_credit = send;   // one input slot frees per send.
    assign bank_req = in_head;

    for (genvar i = 0; i < num_banks; i++) begin : g_credit
        assign bank_req_valid[i] = send && (head_bank == bank_bits'(i));

        always_ff @(posedge clk) begin
            if (reset) begin
                bank_cnt[i] <= cnt_bits'(bank_depth);
            end else begin
                case ({bank_req_valid[i], bank_credit[i]})
                    2'b10: bank_cnt[i] <= bank_cnt[i] - 1'b1;
                    2'b01: bank_cnt[i] <= bank_cnt[i] + 1'b1;
                    default: bank_cnt[i] <= bank_cnt[i];
                endcase
            end
        end

        // A bank returning more credits than it was given breaks this bound.
        a_cnt_bound: assert property (@(posedge clk) disable iff (reset)
            bank_cnt[i] <= cnt_bits'(bank_depth))
            else $error("l2_req_dispatch: bank %0d credit overflow", i);
    end

endmodule

// ==== design/l2_resp_merge.sv ====
`timescale 1ns/1ps

module l2_resp_merge (
    input logic clk,
    input logic reset,
    input logic [l2_pkg::num_banks-1:0] rsp_valid,
    input l2_pkg::l2_resp_t rsp [l2_pkg::num_banks],
    output logic [l2_pkg::num_banks-1:0] rsp_pop,
    output logic resp_valid,
    output l2_pkg::l2_resp_t resp,
    input logic resp_credit
);
    import l2_pkg::*;

    logic [bank_bits-1:0] rr_ptr;
    logic [bank_bits-1:0] sel;
    logic found;
    logic take;
    logic [resp_cnt_bits-1:0] credit_cnt;

    // first valid bank at or after rr_ptr, wrapping around.
    always_comb begin
        logic [bank_bits-1:0] idx;
        found = 1'b0;
        sel = rr_ptr;
        for (int k = 0; k < num_banks; k++) begin
            idx = rr_ptr + bank_bits'(k);
            if (!found && rsp_valid[idx]) begin
                found = 1'b1;
                sel = idx;
            end
        end
    end

    assign take = found && (credit_cnt != '0);

    always_comb begin
        rsp_pop = '0;
        rsp_pop[sel] = take;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
            credit_cnt <= resp_cnt_bits'(resp_credits);
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= take;
            if (take) begin
                rr_ptr <= sel + 1'b1;   // the winner drops to lowest priority.
            end
            case ({take, resp_credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            resp <= rsp[sel];
        end
    end

    // The consumer must never hand back more slots than it owns.
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= resp_cnt_bits'(resp_credits))
        else $error("l2_resp_merge: too many credits returned");

endmodule

// ==== design/l2_subsystem.sv ====
`timescale 1ns/1ps

module l2_subsystem (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input l2_pkg::l2_req_t req,
    output logic req_credit,
    output logic resp_valid,
    output l2_pkg::l2_resp_t resp,
    input logic resp_credit
);
    import l2_pkg::*;

    logic [num_banks-1:0] bank_req_valid;
    l2_req_t bank_req;
    logic [num_banks-1:0] bank_credit;
    logic [num_banks-1:0] rsp_valid;
    l2_resp_t rsp [num_banks];
    logic [num_banks-1:0] rsp_pop;

    l2_req_dispatch l2_req_dispatch_inst (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .req_credit(req_credit),
        .bank_req_valid(bank_req_valid),
        .bank_req(bank_req),
        .bank_credit(bank_credit)
    );

    // every bank sees the same request bus and takes it only on its own valid.
    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        l2_bank l2_bank_inst (
            .clk(clk),
            .reset(reset),
            .req_valid(bank_req_valid[i]),
            .req(bank_req),
            .credit(bank_credit[i]),
            .rsp_valid(rsp_valid[i]),
            .rsp(rsp[i]),
            .rsp_pop(rsp_pop[i])
        );
    end

    l2_resp_merge l2_resp_merge_inst (
        .clk(clk),
        .reset(reset),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .rsp_pop(rsp_pop),
        .resp_valid(resp_valid),
        .resp(resp),
        .resp_credit(resp_credit)
    );

endmodule

// ==== design/l2ram.sv ====
`timescale 1ns/1ps

module l2ram (
    input logic clk,
    input logic rd_en,
    input logic [l2_pkg::row_bits-1:0] rd_addr,
    output logic [l2_pkg::data_bits-1:0] rd_data,
    input logic [l2_pkg::strb_bits-1:0] wr_en,
    input logic [l2_pkg::row_bits-1:0] wr_addr,
    input logic [l2_pkg::data_bits-1:0] wr_data
);
    import l2_pkg::*;

    logic [data_bits-1:0] sram [2**row_bits];

    // Each set bit of wr_en writes one byte lane of the row.
    always_ff @(posedge clk) begin
        for (int b = 0; b < strb_bits; b++) begin
            if (wr_en[b]) begin
                sram[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    // a read of the row being written sees the old word.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= sram[rd_addr];
        end
    end

endmodule

// ==== l2_subsystem.f ====
design/l2_pkg.sv
design/l2_fifo.sv
design/l2ram.sv
design/l2_bank.sv
design/l2_req_dispatch.sv
design/l2_resp_merge.sv
design/l2_subsystem.sv
verification/l2_subsystem_tb.sv

// ==== verification/l2_subsystem_tb.sv ====
`timescale 1ns/1ps

module l2_subsystem_tb;
    import l2_pkg::*;

    localparam int pool_size = 64;
    localparam int n_partial = 32;
    localparam int n_mixed = 400;
    localparam int n_stall = 200;
    localparam int total_reqs = 2 * pool_size + 2 * n_partial + n_mixed + n_stall;
    localparam int timeout_cycles = 30 * total_reqs + 2000;
    localparam int num_tags = 2 ** tag_bits;

    logic clk = 1'b0;
    logic reset;
    logic req_valid;
    l2_req_t req;
    logic req_credit;
    logic resp_valid;
    l2_resp_t resp;
    logic resp_credit;

    logic [data_bits-1:0] model_mem [2 ** addr_bits];   // updated when a write is issued.
    logic [data_bits-1:0] exp_data [num_tags];
    logic tag_busy [num_tags];
    logic [addr_bits-1:0] pool [pool_size];             // addresses that hold defined data.
    logic [31:0] rng = 32'd91410;

    int req_credits = in_depth;
    int granted = 0;       // response credits handed back to the merge stage.
    int used = 0;          // responses seen on resp_valid.
    int owed = 0;
    int outstanding = 0;
    int reads_issued = 0;  // each read is owed exactly one response.
    int hold_left = 0;     // cycles left in which the consumer keeps its credits.
    int next_tag = 0;
    int cycles = 0;
    int data_errs = 0;
    int tag_errs = 0;
    int credit_errs = 0;

    l2_subsystem l2_subsystem_inst (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .req_credit(req_credit),
        .resp_valid(resp_valid),
        .resp(resp),
        .resp_credit(resp_credit)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: traffic did not drain within %0d cycles", timeout_cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_resp(input l2_resp_t got, input logic [data_bits-1:0] exp);
        if (got.data !== exp) begin
            $display("[ERROR] %0t resp.data (tag %0d): got %h, expected %h",
                     $time, got.tag, got.data, exp);
            data_errs++;
        end
    endtask

    task automatic check_tag(input l2_resp_t got, output logic ok);
        ok = tag_busy[got.tag];
        if (!ok) begin
            $display("error at %0t: response with tag %0d has no outstanding read",
                     $time, got.tag);
            tag_errs++;
        end
    endtask

    task automatic check_credit(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            credit_errs++;
        end
    endtask

    task automatic take_response(input l2_resp_t r);
        logic ok;
        used++;
        if (used > resp_credits + granted) begin
            $display("error at %0t: response arrived with no consumer credit left", $time);
            credit_errs++;
        end
        check_tag(r, ok);
        if (ok) begin
            check_resp(r, exp_data[r.tag]);
            tag_busy[r.tag] = 1'b0;
            outstanding--;
        end
        owed++;   // one slot to hand back.
    endtask

    // One clock: observe the DUT, then drive the inputs for the new cycle.
    task automatic cycle_step(input logic send_req, input l2_req_t r);
        logic got_credit;
        @(posedge clk);
        #2;
        got_credit = req_credit;
        if (resp_valid) begin
            take_response(resp);
        end
        if (hold_left > 0) begin
            hold_left--;
        end
        resp_credit = 1'b0;
        if (owed > 0 && hold_left == 0) begin
            resp_credit = 1'b1;
            owed--;
            granted++;
        end
        req_valid = send_req;
        req = r;
        if (send_req) begin
            req_credits--;
        end
        if (got_credit) begin
            req_credits++;   // usable from the next cycle on.
        end
        if (req_credits > in_depth) begin
            $display("error at %0t: requester holds %0d credits, more than %0d",
                     $time, req_credits, in_depth);
            credit_errs++;
        end
    endtask

    task automatic issue(input l2_req_t r);
        while (req_credits == 0) begin
            cycle_step(1'b0, r);
        end
        cycle_step(1'b1, r);
    endtask

    task automatic write_word(input logic [addr_bits-1:0] a, input logic [strb_bits-1:0] be,
                              input logic [data_bits-1:0] d);
        l2_req_t r;
        for (int b = 0; b < strb_bits; b++) begin
            if (be[b]) begin
                model_mem[a][8*b +: 8] = d[8*b +: 8];
            end
        end
        r.write = 1'b1;
        r.addr = a;
        r.byte_en = be;
        r.data = d;
        r.tag = '0;
        issue(r);
    endtask

    task automatic read_word(input logic [addr_bits-1:0] a);
        l2_req_t r;
        int t;
        t = -1;
        while (t < 0) begin
            for (int k = 0; k < num_tags && t < 0; k++) begin
                if (!tag_busy[(next_tag + k) % num_tags]) begin
                    t = (next_tag + k) % num_tags;
                end
            end
            if (t < 0) begin
                cycle_step(1'b0, '0);
            end
        end
        next_tag = (t + 1) % num_tags;
        exp_data[t] = model_mem[a];
        tag_busy[t] = 1'b1;
        outstanding++;
        reads_issued++;
        r.write = 1'b0;
        r.addr = a;
        r.byte_en = '0;
        r.data = '0;
        r.tag = tag_bits'(t);
        issue(r);
    endtask

    task automatic random_op();
        logic [31:0] rnd;
        int idx;
        rnd = next_rand();
        idx = int'(rnd % 32'(pool_size));
        if (rnd[8]) begin
            write_word(pool[idx], rnd[9] ? '1 : rnd[31:16],
                       {next_rand(), next_rand(), next_rand(), next_rand()});
        end else begin
            read_word(pool[idx]);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int idx;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        resp_credit = 1'b0;
        for (int i = 0; i < num_tags; i++) begin
            tag_busy[i] = 1'b0;
        end
        for (int i = 0; i < pool_size; i++) begin
            rnd = next_rand();
            pool[i] = {rnd[row_bits-1:0], bank_bits'(i % num_banks)};   // every bank gets rows.
        end
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        repeat (3) begin
            @(posedge clk);
            #2;
            check_credit("req_credit", int'(req_credit), 0);
            check_credit("resp_valid", int'(resp_valid), 0);
        end

        for (int i = 0; i < pool_size; i++) begin
            write_word(pool[i], '1, {next_rand(), next_rand(), next_rand(), next_rand()});
        end
        for (int i = 0; i < pool_size; i++) begin
            read_word(pool[i]);
        end

        for (int i = 0; i < n_partial; i++) begin
            rnd = next_rand();
            idx = int'(rnd % 32'(pool_size));
            write_word(pool[idx], rnd[31:16],
                       {next_rand(), next_rand(), next_rand(), next_rand()});
            read_word(pool[idx]);
        end

        for (int i = 0; i < n_mixed; i++) begin
            if (next_rand() % 32'd16 == 32'd0) begin
                hold_left = int'(next_rand() % 32'd16);   // a short stall at the consumer.
            end
            random_op();
        end

        // a long stall fills the response queues and backs up the whole path.
        hold_left = 200 + int'(next_rand() % 32'd100);
        for (int i = 0; i < n_stall; i++) begin
            random_op();
        end

        while (outstanding > 0 || owed > 0 || req_credits < in_depth || hold_left > 0) begin
            cycle_step(1'b0, '0);
        end
        repeat (8) cycle_step(1'b0, '0);
        check_credit("requester credits", req_credits, in_depth);
        check_credit("responses received", used, reads_issued);

        $display("errors: data %0d, tag %0d, credit %0d", data_errs, tag_errs, credit_errs);
        if (data_errs + tag_errs + credit_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
